// ==== include/mipsCore_macros.svh ====
// ####################
// mipsCore macros: widths, reset PC and
// opcode/funct encodings of the supported instructions
// ####################
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

`define MIPS_DATA_W    32            // word width
`define MIPS_ADDR_W    32            // byte address width
`define MIPS_REG_W     5             // register number width
`define MIPS_BE_W      4             // byte enables per word
`define MIPS_REG_N     32            // general purpose registers
`define MIPS_RESET_PC  32'h0000_0000 // first fetch address

`define MIPS_OP_SPECIAL 6'h00 // register-register group, op in funct
`define MIPS_OP_J       6'h02
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a
`define MIPS_FN_SLTU    6'h2b

`endif

// ==== source/mipsPkg.sv ====
// ####################
// mipsPkg: shared vector types and the
// decoded operation enum of the pipeline
// ####################
`include "mipsCore_macros.svh"

package mipsPkg;

    typedef logic [`MIPS_DATA_W-1:0] wordT;   // data word
    typedef logic [`MIPS_ADDR_W-1:0] addrT;   // byte address
    typedef logic [`MIPS_REG_W-1:0]  regNumT; // register number
    typedef logic [`MIPS_BE_W-1:0]   byteEnT; // per-byte write enables

    // opNop must stay zero, an all-zero bubble decodes as nop
    typedef enum logic [4:0] {
        opNop   = 5'd0,
        opAddu,             // register-register group
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opAddiu,            // immediate group
        opAndi,
        opOri,
        opXori,
        opSlti,
        opLui,
        opLw,               // memory
        opSw,
        opBeq,              // control, resolved in decode
        opBne,
        opJ
    } opnT;

endpackage

// ==== source/regFile.sv ====
// ####################
// regFile: 32x32 register file, two combinational
// reads with write-through, one write port
// ####################
`include "mipsCore_macros.svh"

module regFile (
    input  logic           CLK,
    input  mipsPkg::regNumT rdNum0,
    input  mipsPkg::regNumT rdNum1,
    output mipsPkg::wordT   rdData0,
    output mipsPkg::wordT   rdData1,
    input  mipsPkg::regNumT wrNum,
    input  mipsPkg::wordT   wrData,
    input  logic           wrEn
);
    import mipsPkg::*;

    wordT regs [`MIPS_REG_N]; // r0 slot exists but is never read

    // r0 reads zero, same-cycle write is bypassed to the reader
    assign rdData0 = (rdNum0 == '0) ? '0 :
                     (wrEn && wrNum == rdNum0) ? wrData : regs[rdNum0];
    assign rdData1 = (rdNum1 == '0) ? '0 :
                     (wrEn && wrNum == rdNum1) ? wrData : regs[rdNum1];

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            regs[wrNum] <= wrData; // writes to r0 are harmless, never read back
        end
    end

    // once memory stage leaves reset its destination is defined, the stall-driven
    // enable must be defined by then as well
    aWrEnKnown: assert property (@(posedge CLK) !$isunknown(wrNum) |-> !$isunknown(wrEn));

endmodule

// ==== source/fetchStage.sv ====
// ####################
// fetchStage: program counter and the
// fetch/decode pipeline register
// ####################
`include "mipsCore_macros.svh"

module fetchStage (
    input  logic          CLK,
    input  logic          RST_X,
    input  logic          stall,        // external freeze
    input  logic          branchStall,  // decode waits on a branch source
    input  logic          branchTaken,
    input  mipsPkg::addrT branchTarget,
    output mipsPkg::addrT iAddr,
    input  mipsPkg::wordT iData,
    output mipsPkg::addrT ifIdNpc,
    output mipsPkg::wordT ifIdInstr
);
    import mipsPkg::*;

    addrT pc;
    addrT pcPlus4;
    logic hold;

    assign pcPlus4 = pc + 32'd4;
    assign hold    = stall || branchStall;
    assign iAddr   = pc; // imem answers in the same cycle

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            pc        <= `MIPS_RESET_PC;
            ifIdNpc   <= '0;
            ifIdInstr <= '0;  // zero word decodes as nop
        end else if (!hold) begin
            pc        <= branchTaken ? branchTarget : pcPlus4; // redirect after delay slot
            ifIdNpc   <= pcPlus4;
            ifIdInstr <= iData;
        end
    end

    aPcAligned: assert property (@(posedge CLK) disable iff (!RST_X) pc[1:0] == 2'b00);

endmodule

// ==== source/decodeStage.sv ====
// ####################
// decodeStage: decoder, branch/jump resolution,
// branch stall and the decode/execute register
// ####################
`include "mipsCore_macros.svh"

module decodeStage (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            stall,
    input  mipsPkg::addrT   ifIdNpc,
    input  mipsPkg::wordT   ifIdInstr,
    input  mipsPkg::wordT   rdData0,       // R[rs]
    input  mipsPkg::wordT   rdData1,       // R[rt]
    input  mipsPkg::regNumT exDst,         // dst held in decode/execute
    input  mipsPkg::regNumT maDst,         // dst held in execute/memory
    output mipsPkg::regNumT rdNum0,
    output mipsPkg::regNumT rdNum1,
    output logic            branchStall,
    output logic            branchTaken,
    output mipsPkg::addrT   branchTarget,
    output mipsPkg::opnT    idExOpn,
    output mipsPkg::wordT   idExSrcA,
    output mipsPkg::wordT   idExSrcB,
    output mipsPkg::regNumT idExNumA,
    output mipsPkg::regNumT idExNumB,
    output mipsPkg::regNumT idExDst,
    output logic [15:0]     idExImm,
    output logic            idExLoad,
    output logic            idExStore
);
    import mipsPkg::*;

    logic [5:0]  opCode;
    logic [5:0]  funct;
    regNumT      rs;
    regNumT      rt;
    regNumT      rd;
    logic [15:0] imm;
    opnT         opn;
    regNumT      dst;
    logic        isBranch;   // beq/bne only, j needs no operands
    logic        srcEq;
    addrT        brTarget;
    addrT        jTarget;

    assign opCode = ifIdInstr[31:26];
    assign rs     = ifIdInstr[25:21];
    assign rt     = ifIdInstr[20:16];
    assign rd     = ifIdInstr[15:11];
    assign imm    = ifIdInstr[15:0];
    assign funct  = ifIdInstr[5:0];
    assign rdNum0 = rs;
    assign rdNum1 = rt;

    always_comb begin
        opn = opNop; // unknown encodings fall through as nop
        case (opCode)
            `MIPS_OP_SPECIAL: begin
                case (funct)
                    `MIPS_FN_ADDU: opn = opAddu;
                    `MIPS_FN_SUBU: opn = opSubu;
                    `MIPS_FN_AND:  opn = opAnd;
                    `MIPS_FN_OR:   opn = opOr;
                    `MIPS_FN_XOR:  opn = opXor;
                    `MIPS_FN_NOR:  opn = opNor;
                    `MIPS_FN_SLT:  opn = opSlt;
                    `MIPS_FN_SLTU: opn = opSltu;
                    default:       opn = opNop;
                endcase
            end
            `MIPS_OP_ADDIU: opn = opAddiu;
            `MIPS_OP_ANDI:  opn = opAndi;
            `MIPS_OP_ORI:   opn = opOri;
            `MIPS_OP_XORI:  opn = opXori;
            `MIPS_OP_SLTI:  opn = opSlti;
            `MIPS_OP_LUI:   opn = opLui;
            `MIPS_OP_LW:    opn = opLw;
            `MIPS_OP_SW:    opn = opSw;
            `MIPS_OP_BEQ:   opn = opBeq;
            `MIPS_OP_BNE:   opn = opBne;
            `MIPS_OP_J:     opn = opJ;
            default:        opn = opNop;
        endcase
    end

    // rd for reg-reg ops, rt for immediates and loads, none otherwise
    assign dst = (opn inside {opAddu, opSubu, opAnd, opOr, opXor, opNor, opSlt, opSltu}) ? rd :
                 (opn inside {opAddiu, opAndi, opOri, opXori, opSlti, opLui, opLw}) ? rt : '0;

    assign isBranch = (opn == opBeq) || (opn == opBne);
    assign srcEq    = (rdData0 == rdData1);
    assign brTarget = ifIdNpc + {{14{imm[15]}}, imm, 2'b00};        // npc + sext(off)*4
    assign jTarget  = {ifIdNpc[31:28], ifIdInstr[25:0], 2'b00};     // region of the delay slot

    assign branchTaken  = (opn == opJ) || (opn == opBeq && srcEq) || (opn == opBne && !srcEq);
    assign branchTarget = (opn == opJ) ? jTarget : brTarget;

    // operand still being computed further down, wait for it to reach the regfile
    assign branchStall = isBranch &&
                         ((rs != '0 && (rs == exDst || rs == maDst)) ||
                          (rt != '0 && (rt == exDst || rt == maDst)));

    always_ff @(posedge CLK) begin
        if (!RST_X || (branchStall && !stall)) begin // reset state doubles as bubble
            idExOpn   <= opNop;
            idExSrcA  <= '0;
            idExSrcB  <= '0;
            idExNumA  <= '0;
            idExNumB  <= '0;
            idExDst   <= '0;
            idExImm   <= '0;
            idExLoad  <= 1'b0;
            idExStore <= 1'b0;
        end else if (!stall) begin
            idExOpn   <= opn;
            idExSrcA  <= rdData0;
            idExSrcB  <= rdData1;
            idExNumA  <= rs;       // kept for forwarding compare
            idExNumB  <= rt;
            idExDst   <= dst;
            idExImm   <= imm;
            idExLoad  <= (opn == opLw);
            idExStore <= (opn == opSw);
        end
    end

endmodule

// ==== source/executeStage.sv ====
// ####################
// executeStage: operand forwarding, ALU, address
// generation, data port and execute/memory register
// ####################
module executeStage (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            stall,
    input  mipsPkg::opnT    idExOpn,
    input  mipsPkg::wordT   idExSrcA,
    input  mipsPkg::wordT   idExSrcB,
    input  mipsPkg::regNumT idExNumA,
    input  mipsPkg::regNumT idExNumB,
    input  mipsPkg::regNumT idExDst,
    input  logic [15:0]     idExImm,
    input  logic            idExLoad,
    input  logic            idExStore,
    input  mipsPkg::wordT   maRslt,     // first forwarding level
    input  mipsPkg::regNumT maDst,
    input  mipsPkg::wordT   wbRslt,     // second forwarding level
    input  mipsPkg::regNumT wbDst,
    output mipsPkg::regNumT exDst,
    output mipsPkg::addrT   dAddr,
    output mipsPkg::wordT   dWdata,
    output mipsPkg::byteEnT dWe,
    output logic            dOe,
    output mipsPkg::wordT   exMaRslt,
    output mipsPkg::regNumT exMaDst,
    output logic            exMaLoad
);
    import mipsPkg::*;

    wordT opA;
    wordT opB;
    wordT immSext;
    wordT immZext;
    addrT memAddr;
    wordT aluRslt;

    // youngest producer wins and r0 is never forwarded
    function automatic wordT fwdSel(input regNumT num, input wordT readVal,
                                    input regNumT dst1, input wordT val1,
                                    input regNumT dst2, input wordT val2);
        if (num != '0 && num == dst1) begin
            return val1;
        end
        if (num != '0 && num == dst2) begin
            return val2;
        end
        return readVal;
    endfunction

    assign opA     = fwdSel(idExNumA, idExSrcA, maDst, maRslt, wbDst, wbRslt);
    assign opB     = fwdSel(idExNumB, idExSrcB, maDst, maRslt, wbDst, wbRslt);
    assign immSext = {{16{idExImm[15]}}, idExImm};
    assign immZext = {16'h0000, idExImm};        // logical immediates
    assign memAddr = (opA + immSext) & 32'hffff_fffc; // word aligned

    always_comb begin
        case (idExOpn)
            opAddu:  aluRslt = opA + opB;
            opSubu:  aluRslt = opA - opB;
            opAnd:   aluRslt = opA & opB;
            opOr:    aluRslt = opA | opB;
            opXor:   aluRslt = opA ^ opB;
            opNor:   aluRslt = ~(opA | opB);
            opSlt:   aluRslt = {31'd0, $signed(opA) < $signed(opB)};
            opSltu:  aluRslt = {31'd0, opA < opB};
            opAddiu: aluRslt = opA + immSext;
            opAndi:  aluRslt = opA & immZext;
            opOri:   aluRslt = opA | immZext;
            opXori:  aluRslt = opA ^ immZext;
            opSlti:  aluRslt = {31'd0, $signed(opA) < $signed(immSext)};
            opLui:   aluRslt = {idExImm, 16'h0000};
            opLw:    aluRslt = memAddr;  // replaced by load data in memory stage
            opSw:    aluRslt = memAddr;
            default: aluRslt = '0;       // nop, branches, bubbles
        endcase
    end

    assign exDst  = idExDst;                              // branch stall compare in decode
    assign dAddr  = memAddr;
    assign dWdata = opB;                                  // store data is forwarded rt
    assign dWe    = (idExStore && !stall) ? '1 : '0;      // word stores only
    assign dOe    = idExLoad && !stall;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            exMaRslt <= '0;
            exMaDst  <= '0;
            exMaLoad <= 1'b0;
        end else if (!stall) begin
            exMaRslt <= aluRslt;
            exMaDst  <= idExDst;
            exMaLoad <= idExLoad;
        end
    end

    // data port never reads and writes in the same cycle
    aPortExcl: assert property (@(posedge CLK) disable iff (!RST_X) !((|dWe) && dOe));

endmodule

// ==== source/memoryStage.sv ====
// ####################
// memoryStage: load select, register write
// port and the memory/writeback register
// ####################
module memoryStage (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            stall,
    input  mipsPkg::wordT   exMaRslt,
    input  mipsPkg::regNumT exMaDst,
    input  logic            exMaLoad,
    input  mipsPkg::wordT   dRdata,   // sync read, valid one cycle after dOe
    output mipsPkg::regNumT wrNum,
    output mipsPkg::wordT   wrData,
    output logic            wrEn,
    output mipsPkg::wordT   wbRslt,
    output mipsPkg::regNumT wbDst
);

    assign wrNum  = exMaDst;                          // bubbles carry r0
    assign wrData = exMaLoad ? dRdata : exMaRslt;
    assign wrEn   = !stall;                           // no write while frozen

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            wbRslt <= '0;
            wbDst  <= '0;
        end else if (!stall) begin
            wbRslt <= wrData;  // second forwarding level, includes load data
            wbDst  <= exMaDst;
        end
    end

endmodule

// ==== source/mipsCore.sv ====
// ####################
// mipsCore: five-stage MIPS pipeline with
// separate instruction and data ports
// ####################
module mipsCore (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            stall,   // level, freezes every stage
    output mipsPkg::addrT   iAddr,
    input  mipsPkg::wordT   iData,   // combinational imem
    output mipsPkg::addrT   dAddr,
    output mipsPkg::wordT   dWdata,
    input  mipsPkg::wordT   dRdata,  // synchronous dmem
    output mipsPkg::byteEnT dWe,
    output logic            dOe
);
    import mipsPkg::*;

    addrT   ifIdNpc;
    wordT   ifIdInstr;
    logic   branchStall;
    logic   branchTaken;
    addrT   branchTarget;
    regNumT rdNum0;
    regNumT rdNum1;
    wordT   rdData0;
    wordT   rdData1;
    opnT    idExOpn;
    wordT   idExSrcA;
    wordT   idExSrcB;
    regNumT idExNumA;
    regNumT idExNumB;
    regNumT idExDst;
    logic [15:0] idExImm;
    logic   idExLoad;
    logic   idExStore;
    regNumT exDst;
    wordT   exMaRslt;
    regNumT exMaDst;
    logic   exMaLoad;
    regNumT wrNum;
    wordT   wrData;
    logic   wrEn;
    wordT   wbRslt;
    regNumT wbDst;

    fetchStage fetch0 (
        .CLK, .RST_X, .stall, .branchStall, .branchTaken, .branchTarget,
        .iAddr, .iData, .ifIdNpc, .ifIdInstr
    );

    decodeStage decode0 (
        .CLK, .RST_X, .stall, .ifIdNpc, .ifIdInstr, .rdData0, .rdData1,
        .exDst, .maDst(exMaDst), .rdNum0, .rdNum1, .branchStall, .branchTaken,
        .branchTarget, .idExOpn, .idExSrcA, .idExSrcB, .idExNumA, .idExNumB,
        .idExDst, .idExImm, .idExLoad, .idExStore
    );

    executeStage exec0 (
        .CLK, .RST_X, .stall, .idExOpn, .idExSrcA, .idExSrcB, .idExNumA,
        .idExNumB, .idExDst, .idExImm, .idExLoad, .idExStore,
        .maRslt(exMaRslt), .maDst(exMaDst), .wbRslt, .wbDst, .exDst,
        .dAddr, .dWdata, .dWe, .dOe, .exMaRslt, .exMaDst, .exMaLoad
    );

    memoryStage mem0 (
        .CLK, .RST_X, .stall, .exMaRslt, .exMaDst, .exMaLoad, .dRdata,
        .wrNum, .wrData, .wrEn, .wbRslt, .wbDst
    );

    regFile regs0 (
        .CLK, .rdNum0, .rdNum1, .rdData0, .rdData1, .wrNum, .wrData, .wrEn
    );

endmodule

// ==== bench/tbMem.sv ====
// ####################
// tbMem: combinational instruction memory and
// synchronous-read data memory with a store flag
// ####################
`include "mipsCore_macros.svh"

module tbMem (
    input  logic            CLK,
    input  mipsPkg::addrT   iAddr,
    output mipsPkg::wordT   iData,
    input  mipsPkg::addrT   dAddr,
    input  mipsPkg::wordT   dWdata,
    output mipsPkg::wordT   dRdata,
    input  mipsPkg::byteEnT dWe,
    input  logic            dOe,
    output logic            storeFlag    // high in every cycle that commits a store
);
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int IMEM_N = 64;
    localparam int DMEM_N = 64;

    wordT imem [IMEM_N];  // filled by the testbench
    wordT dmem [DMEM_N];

    initial begin
        dRdata = '0;
        for (int i = 0; i < IMEM_N; i++) begin
            imem[i] = '0;                                    // zero word is a nop
        end
        for (int i = 0; i < DMEM_N; i++) begin
            dmem[i] = 32'ha500_0000 ^ (32'(i) * 32'h0001_0004); // unique per word
        end
    end

    assign iData     = imem[iAddr[7:2]];  // same-cycle fetch
    assign storeFlag = |dWe;

    always @(posedge CLK) begin
        for (int b = 0; b < `MIPS_BE_W; b++) begin
            if (dWe[b]) begin
                dmem[dAddr[7:2]][8*b +: 8] <= dWdata[8*b +: 8];
            end
        end
        if (dOe) begin
            dRdata <= dmem[dAddr[7:2]]; // held until the next load
        end
    end

endmodule

// ==== bench/tbMipsCore.sv ====
// ####################
// tbMipsCore: runs a table-driven program twice
// and checks every store against the expected list
// ####################
`include "mipsCore_macros.svh"

module tbMipsCore;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int PROG_LEN    = 52;
    localparam int STORE_N     = 22;
    localparam int CYCLE_LIMIT = 2 * (4 * PROG_LEN + 50);

    logic   CLK;
    logic   RST_X;
    logic   stall;
    addrT   iAddr;
    wordT   iData;
    addrT   dAddr;
    wordT   dWdata;
    wordT   dRdata;
    byteEnT dWe;
    logic   dOe;
    logic   storeFlag;

    wordT        progTable [PROG_LEN];
    logic [63:0] expTable [STORE_N];   // {address, data} per store
    int          errors;
    int          compared;
    int          cycles;
    integer      seed;
    integer      randWord;
    logic        stallOn;              // random stall enable for the run

    mipsCore dut0 (
        .CLK, .RST_X, .stall, .iAddr, .iData, .dAddr, .dWdata, .dRdata, .dWe, .dOe
    );

    tbMem mem0 (
        .CLK, .iAddr, .iData, .dAddr, .dWdata, .dRdata, .dWe, .dOe, .storeFlag
    );

    always #2 CLK = ~CLK;

    function automatic wordT regOp(input logic [5:0] fn, input regNumT rs,
                                   input regNumT rt, input regNumT rd);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT immOp(input logic [5:0] op, input regNumT rs,
                                   input regNumT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpTo(input int index);
        return {`MIPS_OP_J, 26'(index)};       // word index within the same 256 MB region
    endfunction

    task automatic loadProgram();
        progTable[0]  = immOp(`MIPS_OP_LUI,   0, 1, 16'h1234);  // lui  r1, 0x1234
        progTable[1]  = immOp(`MIPS_OP_ORI,   1, 1, 16'h5678);  // ori  r1, r1, 0x5678
        progTable[2]  = immOp(`MIPS_OP_LUI,   0, 2, 16'hf0f0);  // lui  r2, 0xf0f0
        progTable[3]  = immOp(`MIPS_OP_ORI,   2, 2, 16'h0ff0);  // ori  r2, r2, 0x0ff0
        progTable[4]  = regOp(`MIPS_FN_ADDU,  1, 2, 3);         // addu r3, r1, r2
        progTable[5]  = immOp(`MIPS_OP_SW,    0, 3, 16'h0000);
        progTable[6]  = regOp(`MIPS_FN_SUBU,  1, 3, 4);         // subu r4, r1, r3
        progTable[7]  = immOp(`MIPS_OP_SW,    0, 4, 16'h0004);
        progTable[8]  = regOp(`MIPS_FN_AND,   4, 1, 5);         // and  r5, r4, r1
        progTable[9]  = immOp(`MIPS_OP_SW,    0, 5, 16'h0008);
        progTable[10] = regOp(`MIPS_FN_OR,    5, 2, 6);         // or   r6, r5, r2
        progTable[11] = immOp(`MIPS_OP_SW,    0, 6, 16'h000c);
        progTable[12] = regOp(`MIPS_FN_XOR,   6, 1, 7);         // xor  r7, r6, r1
        progTable[13] = immOp(`MIPS_OP_SW,    0, 7, 16'h0010);
        progTable[14] = regOp(`MIPS_FN_NOR,   7, 4, 8);         // nor  r8, r7, r4
        progTable[15] = immOp(`MIPS_OP_SW,    0, 8, 16'h0014);
        progTable[16] = regOp(`MIPS_FN_SLT,   7, 8, 9);         // slt  r9, r7, r8
        progTable[17] = immOp(`MIPS_OP_SW,    0, 9, 16'h0018);
        progTable[18] = regOp(`MIPS_FN_SLTU,  9, 7, 10);        // sltu r10, r9, r7
        progTable[19] = immOp(`MIPS_OP_SW,    0, 10, 16'h001c);
        progTable[20] = immOp(`MIPS_OP_ADDIU, 10, 11, 16'hfffd); // addiu r11, r10, -3
        progTable[21] = immOp(`MIPS_OP_SW,    0, 11, 16'h0020);
        progTable[22] = immOp(`MIPS_OP_ANDI,  11, 12, 16'h8f0f);
        progTable[23] = immOp(`MIPS_OP_SW,    0, 12, 16'h0024);
        progTable[24] = immOp(`MIPS_OP_ORI,   12, 13, 16'hf000);
        progTable[25] = immOp(`MIPS_OP_SW,    0, 13, 16'h0028);
        progTable[26] = immOp(`MIPS_OP_XORI,  13, 14, 16'h8001);
        progTable[27] = immOp(`MIPS_OP_SW,    0, 14, 16'h002c);
        progTable[28] = immOp(`MIPS_OP_SLTI,  14, 15, 16'h8000); // sign-extended compare
        progTable[29] = immOp(`MIPS_OP_SW,    0, 15, 16'h0030);
        progTable[30] = immOp(`MIPS_OP_LW,    0, 16, 16'h0004);  // lw r16, 4(r0)
        progTable[31] = immOp(`MIPS_OP_ADDIU, 0, 17, 16'h0055);  // load delay slot
        progTable[32] = immOp(`MIPS_OP_SW,    0, 16, 16'h0034);
        progTable[33] = immOp(`MIPS_OP_ADDIU, 0, 18, 16'h0055);
        progTable[34] = immOp(`MIPS_OP_BEQ,   18, 17, 16'h0002); // stalls on r18 and is taken
        progTable[35] = immOp(`MIPS_OP_SW,    0, 18, 16'h0038);  // delay slot
        progTable[36] = immOp(`MIPS_OP_SW,    0, 18, 16'h007c);  // skipped
        progTable[37] = immOp(`MIPS_OP_BNE,   18, 16, 16'h0002); // taken
        progTable[38] = immOp(`MIPS_OP_SW,    0, 17, 16'h003c);
        progTable[39] = immOp(`MIPS_OP_SW,    0, 17, 16'h0078);  // skipped
        progTable[40] = immOp(`MIPS_OP_BEQ,   18, 16, 16'h0002); // not taken
        progTable[41] = immOp(`MIPS_OP_SW,    0, 16, 16'h0040);
        progTable[42] = immOp(`MIPS_OP_SW,    0, 14, 16'h0044);  // fall-through path
        progTable[43] = immOp(`MIPS_OP_BNE,   17, 18, 16'h0002); // not taken
        progTable[44] = immOp(`MIPS_OP_SW,    0, 13, 16'h0048);
        progTable[45] = immOp(`MIPS_OP_SW,    0, 11, 16'h004c);
        progTable[46] = jumpTo(49);
        progTable[47] = immOp(`MIPS_OP_SW,    0, 12, 16'h0050);  // delay slot
        progTable[48] = immOp(`MIPS_OP_SW,    0, 12, 16'h0074);  // skipped
        progTable[49] = immOp(`MIPS_OP_SW,    0, 9, 16'h0054);
        progTable[50] = jumpTo(50);                              // park here
        progTable[51] = 32'h0000_0000;
        for (int i = 0; i < PROG_LEN; i++) begin
            mem0.imem[i] = progTable[i];
        end
    endtask

    task automatic fillExpected();
        expTable[0]  = {32'h0000_0000, 32'h0324_6668};  // addu
        expTable[1]  = {32'h0000_0004, 32'h0f0f_f010};  // subu
        expTable[2]  = {32'h0000_0008, 32'h0204_5010};  // and
        expTable[3]  = {32'h0000_000c, 32'hf2f4_5ff0};  // or
        expTable[4]  = {32'h0000_0010, 32'he0c0_0988};  // xor
        expTable[5]  = {32'h0000_0014, 32'h1030_0667};  // nor
        expTable[6]  = {32'h0000_0018, 32'h0000_0001};  // slt with negative below positive
        expTable[7]  = {32'h0000_001c, 32'h0000_0001};  // sltu
        expTable[8]  = {32'h0000_0020, 32'hffff_fffe};  // addiu
        expTable[9]  = {32'h0000_0024, 32'h0000_8f0e};  // andi zero-extends
        expTable[10] = {32'h0000_0028, 32'h0000_ff0e};  // ori
        expTable[11] = {32'h0000_002c, 32'h0000_7f0f};  // xori
        expTable[12] = {32'h0000_0030, 32'h0000_0000};  // slti
        expTable[13] = {32'h0000_0034, 32'h0f0f_f010};  // loaded word
        expTable[14] = {32'h0000_0038, 32'h0000_0055};
        expTable[15] = {32'h0000_003c, 32'h0000_0055};
        expTable[16] = {32'h0000_0040, 32'h0f0f_f010};
        expTable[17] = {32'h0000_0044, 32'h0000_7f0f};
        expTable[18] = {32'h0000_0048, 32'h0000_ff0e};
        expTable[19] = {32'h0000_004c, 32'hffff_fffe};
        expTable[20] = {32'h0000_0050, 32'h0000_8f0e};
        expTable[21] = {32'h0000_0054, 32'h0000_0001};  // jump landing
    endtask

    task automatic checkIdle(input string phase);
        if (dWe !== '0) begin
            errors++;
            $display("FAILED dWe %s: got %h expected %h", phase, dWe, 4'h0);
        end
        if (dOe !== 1'b0) begin
            errors++;
            $display("FAILED dOe %s: got %h expected %h", phase, dOe, 1'b0);
        end
        if (iAddr !== `MIPS_RESET_PC) begin
            errors++;
            $display("FAILED iAddr %s: got %h expected %h", phase, iAddr, `MIPS_RESET_PC);
        end
    endtask

    task automatic applyReset(input bit randomStall);
        @(negedge CLK);
        stallOn = 1'b0;         // stall low through reset
        @(posedge CLK);
        #1;
        RST_X = 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        checkIdle("during reset");
        @(posedge CLK);
        #1;
        RST_X = 1'b1;           // two cycles low
        @(negedge CLK);
        checkIdle("after reset");
        stallOn = randomStall;
    endtask

    task automatic waitStore();
        do begin
            @(negedge CLK);     // outputs settled and inputs only move after posedge
        end while (!storeFlag);
    endtask

    task automatic runProgram(input bit randomStall);
        logic [63:0] expEntry;
        applyReset(randomStall);
        for (int i = 0; i < STORE_N; i++) begin
            expEntry = expTable[i];
            waitStore();
            compared++;
            if (dAddr !== expEntry[63:32]) begin
                errors++;
                $display("FAILED dAddr store %0d: got %h expected %h", i, dAddr, expEntry[63:32]);
            end
            if (dWdata !== expEntry[31:0]) begin
                errors++;
                $display("FAILED dWdata store %0d: got %h expected %h", i, dWdata, expEntry[31:0]);
            end
        end
        repeat (20) begin
            @(negedge CLK);
            if (storeFlag) begin
                errors++;
                $display("Extra store after the expected list, address %h", dAddr);
            end
        end
    endtask

    // random stall changed just after each rising edge
    always @(posedge CLK) begin
        #1;
        if (stallOn) begin
            randWord = $random(seed);
            stall = randWord[0];
        end else begin
            stall = 1'b0;
        end
    end

    always @(negedge CLK) begin
        if (storeFlag && stall) begin
            errors++;
            $display("A store was issued while stall was high, address %h", dAddr);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the expected stores did not all arrive", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        CLK      = 1'b0;
        RST_X    = 1'b0;
        stall    = 1'b0;
        stallOn  = 1'b0;
        errors   = 0;
        compared = 0;
        cycles   = 0;
        seed     = 30069;
        #1;                     // after tbMem clears its memories at time zero
        loadProgram();
        fillExpected();
        runProgram(1'b0);       // no stall
        runProgram(1'b1);       // same program under random stall
        $display("%0d stores compared, %0d errors", compared, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
source/mipsPkg.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsCore.sv
bench/tbMem.sv
bench/tbMipsCore.sv

// ==== Bender.yml ====
package:
  name: mipsCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mipsPkg.sv
      - source/regFile.sv
      - source/fetchStage.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/memoryStage.sv
      - source/mipsCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tbMem.sv
      - bench/tbMipsCore.sv
